/* all.f */
hdl/cpuPkg.sv
hdl/controlSequencer.sv
hdl/instrDecode.sv
hdl/regFile.sv
hdl/aluExecute.sv
hdl/busWriteback.sv
hdl/programMem.sv
hdl/cpuTop.sv
dv/cpuTb.sv

/* dv/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;

    localparam int MEM_DEPTH = 64;
    localparam int ADDR_W = $clog2(MEM_DEPTH);
    localparam int PROG_LEN = 24;
    localparam int NUM_PROGS = 20;
    localparam int TIMEOUT = 20 * (MEM_DEPTH + PROG_LEN * 40);

    logic clk;
    logic rst;
    logic start;
    logic loadValid;
    logic [ADDR_W-1:0] loadAddr;
    cpuPkg::word_t loadData;
    logic inValid;
    cpuPkg::word_t inData;
    logic outReady;
    logic loadReady;
    logic inReady;
    logic outValid;
    cpuPkg::word_t outData;
    logic halted;

    logic [31:0] seed;
    int errors;
    int checks;
    int cycles;
    int inIdx;
    cpuPkg::word_t prog [PROG_LEN];
    cpuPkg::word_t mregs [16];   // Model register file, kept across programs
    cpuPkg::word_t inQ [$];
    cpuPkg::word_t expQ [$];

    cpuTop #(.MEM_DEPTH(MEM_DEPTH)) UUT (
        .clk(clk), .rst(rst), .start(start),
        .loadValid(loadValid), .loadAddr(loadAddr), .loadData(loadData),
        .inValid(inValid), .inData(inData), .outReady(outReady),
        .loadReady(loadReady), .inReady(inReady), .outValid(outValid),
        .outData(outData), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the CPU never finished its programs", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Rotated so the low bits come from the good upper LCG bits
    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[23:0], seed[31:24]};
    endfunction

    function automatic logic coin();
        logic [31:0] r;
        r = nextRand();
        return r[0];
    endfunction

    function automatic cpuPkg::word_t inputWord();
        if (nextRand() % 4 == 0) begin
            return '0;   // Zero often enough to hit the zero branches
        end
        return nextRand();
    endfunction

    task automatic checkValue(input string name, input cpuPkg::word_t got,
                              input cpuPkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %08h, expected %08h", name, got, exp);
        end
    endtask

    task automatic buildProgram(input int p);
        int k;
        int c;
        cpuPkg::regSel_t ra;
        cpuPkg::regSel_t rb;
        cpuPkg::regSel_t rc;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            ra = 4'(nextRand());
            rb = 4'(nextRand());
            rc = 4'(nextRand());
            k = int'(nextRand() % 10);
            if (p == 0 && i < 16) begin
                prog[i] = {cpuPkg::opIn, 4'(i), 23'(nextRand())};   // Define every register
            end else if (k < 4) begin
                if (k == 1 && coin()) rc = rb;
                case (k)
                    0: prog[i] = {cpuPkg::opAdd, ra, rb, rc, 15'(nextRand())};
                    1: prog[i] = {cpuPkg::opSub, ra, rb, rc, 15'(nextRand())};
                    2: prog[i] = {cpuPkg::opAnd, ra, rb, rc, 15'(nextRand())};
                    default: prog[i] = {cpuPkg::opOr, ra, rb, rc, 15'(nextRand())};
                endcase
            end else if (k == 4) begin
                prog[i] = {cpuPkg::opAddi, ra, rb, 19'(nextRand())};
            end else if (k == 5) begin
                c = int'(nextRand() % 4);
                if (c > PROG_LEN - 2 - i) c = PROG_LEN - 2 - i;   // Never past the halt
                prog[i] = {cpuPkg::opBr, ra, 2'(nextRand()), 2'(nextRand()), 19'(c)};
            end else if (k == 6) begin
                prog[i] = {cpuPkg::opIn, ra, 23'(nextRand())};
            end else begin
                prog[i] = {cpuPkg::opOut, ra, 23'(nextRand())};
            end
        end
        prog[PROG_LEN-1] = {cpuPkg::opHalt, 27'd0};
    endtask

    // ISA reference model, fills inQ and expQ
    task automatic runModel();
        int pc;
        int steps;
        logic done;
        logic taken;
        cpuPkg::word_t instr;
        cpuPkg::word_t cval;
        cpuPkg::word_t w;
        cpuPkg::opcode_t op;
        cpuPkg::regSel_t ra;
        cpuPkg::regSel_t rb;
        cpuPkg::regSel_t rc;
        inQ.delete();
        expQ.delete();
        pc = 0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 1000) begin
            instr = prog[pc];
            pc++;   // PC already points past the instruction
            steps++;
            op = cpuPkg::opcode_t'(instr[31:27]);
            ra = instr[26:23];
            rb = instr[22:19];
            rc = instr[18:15];
            cval = {{13{instr[18]}}, instr[18:0]};
            case (op)
                cpuPkg::opAdd:  mregs[ra] = mregs[rb] + mregs[rc];
                cpuPkg::opSub:  mregs[ra] = mregs[rb] - mregs[rc];
                cpuPkg::opAnd:  mregs[ra] = mregs[rb] & mregs[rc];
                cpuPkg::opOr:   mregs[ra] = mregs[rb] | mregs[rc];
                cpuPkg::opAddi: mregs[ra] = mregs[rb] + cval;
                cpuPkg::opBr: begin
                    case (instr[20:19])
                        2'd0:    taken = (mregs[ra] == 32'd0);
                        2'd1:    taken = (mregs[ra] != 32'd0);
                        2'd2:    taken = ($signed(mregs[ra]) > 0);
                        default: taken = ($signed(mregs[ra]) < 0);
                    endcase
                    if (taken) pc = pc + int'($signed(cval));
                end
                cpuPkg::opIn: begin
                    w = inputWord();
                    inQ.push_back(w);
                    mregs[ra] = w;
                end
                cpuPkg::opOut:  expQ.push_back(mregs[ra]);
                default:        done = 1'b1;   // Halt
            endcase
        end
    endtask

    task automatic loadWord(input int addr, input cpuPkg::word_t data);
        @(negedge clk);
        loadValid = 1'b1;
        loadAddr = ADDR_W'(addr);
        loadData = data;
        while (!loadReady) @(negedge clk);
    endtask

    task automatic runProgram();
        logic holdValid;
        cpuPkg::word_t heldData;
        holdValid = 1'b0;
        heldData = '0;
        inIdx = 0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!halted) begin
            // Load port must ignore these while running
            loadValid = coin();
            loadAddr = ADDR_W'(nextRand() % PROG_LEN);
            loadData = nextRand();
            checkValue("loadReady", 32'(loadReady), 32'd0);

            inData = (inIdx < inQ.size()) ? inQ[inIdx] : nextRand();
            inValid = coin();
            if (inValid && inReady) begin
                if (inIdx >= inQ.size()) begin
                    errors++;
                    $display("The DUT took an input word that the model never asked for");
                end
                inIdx++;
            end

            outReady = coin();
            if (outValid) begin
                if (holdValid) checkValue("outData held", outData, heldData);
                if (outReady) begin
                    if (expQ.size() == 0) begin
                        errors++;
                        $display("The DUT sent an output word that the model does not expect");
                    end else begin
                        checkValue("outData", outData, expQ.pop_front());
                    end
                    holdValid = 1'b0;
                end else begin
                    holdValid = 1'b1;
                    heldData = outData;
                end
            end else begin
                holdValid = 1'b0;
            end
            @(negedge clk);
        end
        loadValid = 1'b0;
        inValid = 1'b0;
        outReady = 1'b0;
    endtask

    initial begin
        seed = 32'd68723;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        start = 1'b0;
        loadValid = 1'b0;
        loadAddr = '0;
        loadData = '0;
        inValid = 1'b0;
        inData = '0;
        outReady = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkValue("loadReady", 32'(loadReady), 32'd1);
        checkValue("halted", 32'(halted), 32'd0);
        checkValue("inReady", 32'(inReady), 32'd0);
        checkValue("outValid", 32'(outValid), 32'd0);

        for (int p = 0; p < NUM_PROGS; p++) begin
            buildProgram(p);
            runModel();
            for (int i = 0; i < PROG_LEN; i++) begin
                loadWord(i, prog[i]);
            end
            @(negedge clk);
            loadValid = 1'b0;
            runProgram();
            // Every output must be out before halt
            checkValue("outputs left", 32'(expQ.size()), 32'd0);
            checkValue("input words used", 32'(inIdx), 32'(inQ.size()));
            checkValue("outValid", 32'(outValid), 32'd0);
        end

        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* hdl/aluExecute.sv */
`timescale 1ns/1ps

module aluExecute (
    input logic clk,
    input logic rst,
    input cpuPkg::ctrl_t ctrl,
    input cpuPkg::word_t bus,
    output cpuPkg::word_t zData
);

    cpuPkg::word_t y;
    cpuPkg::word_t aluResult;

    always_ff @(posedge clk) begin
        if (rst) begin
            y <= '0;
        end else if (ctrl.yLoad) begin
            y <= bus;
        end
    end

    // Y is operand A, bus is operand B
    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::opSub: aluResult = y - bus;
            cpuPkg::opAnd: aluResult = y & bus;
            cpuPkg::opOr:  aluResult = y | bus;
            default:       aluResult = y + bus;   // add, addi, branch target
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            zData <= '0;
        end else if (ctrl.zLoad) begin
            if (ctrl.incPc) begin
                zData <= bus + 32'd1;   // Fetch increment bypasses Y
            end else begin
                zData <= aluResult;
            end
        end
    end

endmodule

/* hdl/busWriteback.sv */
`timescale 1ns/1ps

module busWriteback (
    input logic clk,
    input logic rst,
    input cpuPkg::ctrl_t ctrl,
    input logic start,
    input cpuPkg::word_t regData,
    input cpuPkg::word_t zData,
    input cpuPkg::word_t mdrData,
    input cpuPkg::word_t constC,
    input cpuPkg::brCond_t brCond,
    input cpuPkg::word_t inData,
    output cpuPkg::word_t bus,
    output logic conBit,
    output cpuPkg::word_t outData
);

    cpuPkg::word_t pc;
    logic condMet;

    // Shared bus driver
    always_comb begin
        case (ctrl.busSrc)
            cpuPkg::srcPc:     bus = pc;
            cpuPkg::srcZ:      bus = zData;
            cpuPkg::srcMdr:    bus = mdrData;
            cpuPkg::srcReg:    bus = regData;
            cpuPkg::srcConst:  bus = constC;
            cpuPkg::srcInPort: bus = inData;
            default:           bus = '0;
        endcase
    end

    // Start only arrives while the sequencer is stopped
    always_ff @(posedge clk) begin
        if (rst || start) begin
            pc <= '0;
        end else if (ctrl.pcLoad) begin
            pc <= bus;
        end
    end

    // CON logic on ra
    always_comb begin
        case (brCond)
            cpuPkg::condZero:     condMet = (bus == '0);
            cpuPkg::condNonzero:  condMet = (bus != '0);
            cpuPkg::condPositive: condMet = !bus[31] && (bus != '0);   // Strictly above zero
            default:              condMet = bus[31];
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            conBit <= 1'b0;
        end else if (ctrl.conLoad) begin
            conBit <= condMet;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.outLoad) begin
            outData <= bus;
        end
    end

endmodule

/* hdl/controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer #(
    parameter int MEM_DEPTH = 64
) (
    input logic clk,
    input logic rst,
    input logic start,
    input logic loadValid,
    input logic inValid,
    input logic outReady,
    input cpuPkg::opcode_t opcode,
    input logic conBit,
    output cpuPkg::ctrl_t ctrl,
    output logic loadReady,
    output logic inReady,
    output logic outValid,
    output logic halted
);

    localparam int cntW = $clog2(MEM_DEPTH) + 1;

    cpuPkg::seqState_t state;
    cpuPkg::seqState_t nextState;
    logic [cntW-1:0] loadCount;   // Words accepted since the last start
    logic stopped;

    assign stopped = (state == cpuPkg::stIdle) || (state == cpuPkg::stHalt);

    // At most one memory's worth of words per load phase
    assign loadReady = stopped && (loadCount != cntW'(MEM_DEPTH));
    assign inReady = (state == cpuPkg::stWaitIn);
    assign outValid = (state == cpuPkg::stWaitOut);
    assign halted = (state == cpuPkg::stHalt);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cpuPkg::stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || (stopped && start)) begin
            loadCount <= '0;
        end else if (loadValid && loadReady) begin
            loadCount <= loadCount + 1'b1;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            cpuPkg::stIdle, cpuPkg::stHalt: if (start) nextState = cpuPkg::stT0;
            cpuPkg::stT0: nextState = cpuPkg::stT1;
            cpuPkg::stT1: nextState = cpuPkg::stT2;
            cpuPkg::stT2: nextState = cpuPkg::stT3;   // IR loads at the end of T2
            cpuPkg::stT3: begin
                case (opcode)
                    cpuPkg::opIn:   nextState = cpuPkg::stWaitIn;
                    cpuPkg::opOut:  nextState = cpuPkg::stWaitOut;
                    cpuPkg::opHalt: nextState = cpuPkg::stHalt;
                    cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
                    cpuPkg::opAddi, cpuPkg::opBr: nextState = cpuPkg::stT4;
                    default: nextState = cpuPkg::stT0;   // Unknown opcode runs as a no-op
                endcase
            end
            cpuPkg::stT4: nextState = cpuPkg::stT5;
            cpuPkg::stT5: nextState = (opcode == cpuPkg::opBr) ? cpuPkg::stT6 : cpuPkg::stT0;
            cpuPkg::stT6: nextState = cpuPkg::stT0;
            cpuPkg::stWaitIn: if (inValid) nextState = cpuPkg::stT0;
            cpuPkg::stWaitOut: if (outReady) nextState = cpuPkg::stT0;
            default: nextState = cpuPkg::stIdle;
        endcase
    end

    // One control word per T-state
    always_comb begin
        ctrl = '0;
        ctrl.aluOp = cpuPkg::opAdd;
        case (state)
            cpuPkg::stT0: begin   // MAR <- PC, Z <- PC + 1
                ctrl.busSrc = cpuPkg::srcPc;
                ctrl.marLoad = 1'b1;
                ctrl.incPc = 1'b1;
                ctrl.zLoad = 1'b1;
            end
            cpuPkg::stT1: begin
                ctrl.busSrc = cpuPkg::srcZ;
                ctrl.pcLoad = 1'b1;
                ctrl.mdrRead = 1'b1;
            end
            cpuPkg::stT2: begin
                ctrl.busSrc = cpuPkg::srcMdr;
                ctrl.irLoad = 1'b1;
            end
            cpuPkg::stT3: begin
                ctrl.busSrc = cpuPkg::srcReg;
                if (opcode == cpuPkg::opBr) begin
                    ctrl.regGrp = cpuPkg::grA;
                    ctrl.conLoad = 1'b1;
                end else if (opcode == cpuPkg::opOut) begin
                    ctrl.regGrp = cpuPkg::grA;
                    ctrl.outLoad = 1'b1;   // Port register holds ra through the wait
                end else begin
                    ctrl.regGrp = cpuPkg::grB;
                    ctrl.yLoad = 1'b1;
                end
            end
            cpuPkg::stT4: begin
                if (opcode == cpuPkg::opBr) begin
                    ctrl.busSrc = cpuPkg::srcPc;
                    ctrl.yLoad = 1'b1;
                end else begin
                    ctrl.busSrc = (opcode == cpuPkg::opAddi) ? cpuPkg::srcConst : cpuPkg::srcReg;
                    ctrl.regGrp = cpuPkg::grC;
                    ctrl.aluOp = opcode;
                    ctrl.zLoad = 1'b1;
                end
            end
            cpuPkg::stT5: begin
                if (opcode == cpuPkg::opBr) begin   // Z <- PC + C
                    ctrl.busSrc = cpuPkg::srcConst;
                    ctrl.zLoad = 1'b1;
                end else begin
                    ctrl.busSrc = cpuPkg::srcZ;
                    ctrl.regGrp = cpuPkg::grA;
                    ctrl.regWrite = 1'b1;
                end
            end
            cpuPkg::stT6: begin
                ctrl.busSrc = cpuPkg::srcZ;
                ctrl.pcLoad = conBit;   // Taken only if CON set
            end
            cpuPkg::stWaitIn: begin
                ctrl.busSrc = cpuPkg::srcInPort;
                ctrl.regGrp = cpuPkg::grA;
                ctrl.regWrite = inValid;
            end
            default: ;
        endcase
    end

endmodule

/* hdl/cpuPkg.sv */
package cpuPkg;

    typedef logic [31:0] word_t;   // Bus, registers, PC, memory data
    typedef logic [3:0] regSel_t;
    typedef logic [1:0] brCond_t;

    // Branch conditions, taken from IR bits 20..19
    localparam brCond_t condZero = 2'd0;
    localparam brCond_t condNonzero = 2'd1;
    localparam brCond_t condPositive = 2'd2;
    localparam brCond_t condNegative = 2'd3;

    localparam int constWidth = 19;   // Signed C field

    typedef enum logic [4:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opAddi = 5'b01100,
        opBr   = 5'b10010,
        opIn   = 5'b10110,
        opOut  = 5'b10111,
        opHalt = 5'b11011
    } opcode_t;

    // rc and lowBits together form C
    typedef struct packed {
        opcode_t opcode;    // 31..27
        regSel_t ra;        // 26..23
        regSel_t rb;        // 22..19
        regSel_t rc;        // 18..15
        logic [14:0] lowBits;
    } instr_t;

    typedef enum logic [3:0] {
        stIdle, stT0, stT1, stT2, stT3, stT4, stT5, stT6, stWaitIn, stWaitOut, stHalt
    } seqState_t;

    typedef enum logic [2:0] {
        srcNone, srcPc, srcZ, srcMdr, srcReg, srcConst, srcInPort
    } busSrc_t;

    typedef enum logic [1:0] {
        grA, grB, grC
    } regGrp_t;

    typedef struct packed {
        busSrc_t busSrc;
        regGrp_t regGrp;
        logic pcLoad;
        logic incPc;       // Z takes bus plus 1
        logic irLoad;
        logic yLoad;
        logic zLoad;
        opcode_t aluOp;
        logic marLoad;
        logic mdrRead;
        logic regWrite;
        logic conLoad;
        logic outLoad;
    } ctrl_t;

endpackage

/* hdl/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop #(
    parameter int MEM_DEPTH = 64
) (
    input logic clk,
    input logic rst,
    input logic start,
    input logic loadValid,
    input logic [$clog2(MEM_DEPTH)-1:0] loadAddr,
    input cpuPkg::word_t loadData,
    input logic inValid,
    input cpuPkg::word_t inData,
    input logic outReady,
    output logic loadReady,
    output logic inReady,
    output logic outValid,
    output cpuPkg::word_t outData,
    output logic halted
);

    cpuPkg::ctrl_t ctrl;
    cpuPkg::word_t bus;
    cpuPkg::opcode_t opcode;
    logic conBit;
    cpuPkg::regSel_t regAddr;
    cpuPkg::word_t constC;
    cpuPkg::brCond_t brCond;
    cpuPkg::word_t regData;
    cpuPkg::word_t zData;
    cpuPkg::word_t mdrData;

    controlSequencer #(.MEM_DEPTH(MEM_DEPTH)) sequencer (
        .clk(clk), .rst(rst), .start(start),
        .loadValid(loadValid), .inValid(inValid), .outReady(outReady),
        .opcode(opcode), .conBit(conBit),
        .ctrl(ctrl), .loadReady(loadReady), .inReady(inReady),
        .outValid(outValid), .halted(halted)
    );

    instrDecode decode (
        .clk(clk), .rst(rst), .ctrl(ctrl), .bus(bus),
        .opcode(opcode), .regAddr(regAddr), .constC(constC), .brCond(brCond)
    );

    regFile regs (
        .clk(clk), .ctrl(ctrl), .regAddr(regAddr), .bus(bus), .regData(regData)
    );

    aluExecute execute (
        .clk(clk), .rst(rst), .ctrl(ctrl), .bus(bus), .zData(zData)
    );

    busWriteback writeback (
        .clk(clk), .rst(rst), .ctrl(ctrl), .start(start),
        .regData(regData), .zData(zData), .mdrData(mdrData),
        .constC(constC), .brCond(brCond), .inData(inData),
        .bus(bus), .conBit(conBit), .outData(outData)
    );

    programMem #(.MEM_DEPTH(MEM_DEPTH)) memory (
        .clk(clk), .ctrl(ctrl),
        .loadValid(loadValid), .loadReady(loadReady),
        .loadAddr(loadAddr), .loadData(loadData),
        .bus(bus), .mdrData(mdrData)
    );

endmodule

/* hdl/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
    input logic clk,
    input logic rst,
    input cpuPkg::ctrl_t ctrl,
    input cpuPkg::word_t bus,
    output cpuPkg::opcode_t opcode,
    output cpuPkg::regSel_t regAddr,
    output cpuPkg::word_t constC,
    output cpuPkg::brCond_t brCond
);

    cpuPkg::instr_t ir;
    logic [cpuPkg::constWidth-1:0] constField;

    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= '0;
        end else if (ctrl.irLoad) begin
            ir <= cpuPkg::instr_t'(bus);
        end
    end

    assign opcode = ir.opcode;
    assign brCond = cpuPkg::brCond_t'(ir.rb[1:0]);   // Bits 20..19

    // Gra / Grb / Grc select
    always_comb begin
        case (ctrl.regGrp)
            cpuPkg::grB: regAddr = ir.rb;
            cpuPkg::grC: regAddr = ir.rc;
            default:     regAddr = ir.ra;
        endcase
    end

    // C overlaps rc
    assign constField = {ir.rc, ir.lowBits};
    assign constC = {{(32 - cpuPkg::constWidth){constField[cpuPkg::constWidth-1]}}, constField};

endmodule

/* hdl/programMem.sv */
`timescale 1ns/1ps

module programMem #(
    parameter int MEM_DEPTH = 64
) (
    input logic clk,
    input cpuPkg::ctrl_t ctrl,
    input logic loadValid,
    input logic loadReady,
    input logic [$clog2(MEM_DEPTH)-1:0] loadAddr,
    input cpuPkg::word_t loadData,
    input cpuPkg::word_t bus,
    output cpuPkg::word_t mdrData
);

    localparam int addrW = $clog2(MEM_DEPTH);

    cpuPkg::word_t mem [MEM_DEPTH];
    logic [addrW-1:0] mar;

    // Load port write
    always_ff @(posedge clk) begin
        if (loadValid && loadReady) begin
            mem[loadAddr] <= loadData;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.marLoad) begin
            mar <= bus[addrW-1:0];   // Low PC bits only
        end
        if (ctrl.mdrRead) begin
            mdrData <= mem[mar];
        end
    end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input logic clk,
    input cpuPkg::ctrl_t ctrl,
    input cpuPkg::regSel_t regAddr,
    input cpuPkg::word_t bus,
    output cpuPkg::word_t regData
);

    cpuPkg::word_t regs [16];

    // Same selected register for read and write
    always_ff @(posedge clk) begin
        if (ctrl.regWrite) begin
            regs[regAddr] <= bus;
        end
    end

    assign regData = regs[regAddr];   // Async read

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 -f all.f --top-module cpuTb -o cpuTbSim

./obj_dir/cpuTbSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failure"
